//--- rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    localparam int NUM_REGS = 32;

    // RV32I major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    localparam word_t RESET_PC  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM
    } fwd_sel_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

endpackage

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          stall,
    input  logic          interlock,
    input  logic          take_branch,
    input  rv_pkg::word_t branch_target,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t imem_addr,
    output rv_pkg::word_t if_pc,
    output rv_pkg::word_t if_instr
);

    rv_pkg::word_t pc;
    rv_pkg::word_t next_pc;

    assign next_pc   = take_branch ? branch_target : pc + 32'd4;
    assign imem_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= rv_pkg::RESET_PC;
        end else if (!interlock && !stall) begin
            pc <= next_pc;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_pc    <= rv_pkg::RESET_PC;
            if_instr <= rv_pkg::NOP_INSTR;
        end else if (!interlock) begin
            if (take_branch) begin
                if_instr <= rv_pkg::NOP_INSTR;
            end else if (!stall) begin
                if_pc    <= pc;
                if_instr <= imem_data;
            end
        end
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              stall,
    input  logic              interlock,
    input  logic              take_branch,
    input  rv_pkg::word_t     if_pc,
    input  rv_pkg::word_t     if_instr,
    input  rv_pkg::word_t     rf_data1,
    input  rv_pkg::word_t     rf_data2,
    input  rv_pkg::fwd_sel_e  fwd_a,
    input  rv_pkg::fwd_sel_e  fwd_b,
    input  rv_pkg::word_t     ex_result,
    input  rv_pkg::word_t     mem_fwd_data,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::opcode_t   id_opcode,
    output rv_pkg::word_t     ex_pc,
    output rv_pkg::word_t     ex_a,
    output rv_pkg::word_t     ex_b,
    output rv_pkg::word_t     ex_imm,
    output rv_pkg::reg_addr_t ex_rs2,
    output rv_pkg::reg_addr_t ex_rd,
    output rv_pkg::opcode_t   ex_opcode,
    output rv_pkg::alu_op_e   ex_alu_op,
    output logic [2:0]        ex_funct3,
    output logic              ex_wr_en
);

    rv_pkg::reg_addr_t rd;
    logic [2:0]        funct3;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_e   alu_op;
    logic              wr_en;
    rv_pkg::word_t     op_a;
    rv_pkg::word_t     op_b;

    function automatic rv_pkg::word_t pick(input rv_pkg::fwd_sel_e sel,
                                           input rv_pkg::word_t rf_val);
        case (sel)
            rv_pkg::FWD_EX:  return ex_result;
            rv_pkg::FWD_MEM: return mem_fwd_data;
            default:         return rf_val;
        endcase
    endfunction

    assign id_opcode = if_instr[6:0];
    assign rd        = if_instr[11:7];
    assign funct3    = if_instr[14:12];
    assign rs1_addr  = if_instr[19:15];
    assign rs2_addr  = if_instr[24:20];

    // Immediate format follows the opcode
    always_comb begin
        case (id_opcode)
            rv_pkg::OPC_LUI:    imm = {if_instr[31:12], 12'b0};
            rv_pkg::OPC_STORE:  imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            rv_pkg::OPC_BRANCH: imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                                       if_instr[30:25], if_instr[11:8], 1'b0};
            rv_pkg::OPC_JAL:    imm = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                                       if_instr[20], if_instr[30:21], 1'b0};
            default:            imm = {{20{if_instr[31]}}, if_instr[31:20]};
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ADD;
        if (id_opcode == rv_pkg::OPC_LUI) begin
            alu_op = rv_pkg::PASS_B;
        end else if (id_opcode == rv_pkg::OPC_OP || id_opcode == rv_pkg::OPC_OPIMM) begin
            case (funct3)
                3'b000: begin
                    // No subtract-immediate in RV32I
                    if (id_opcode == rv_pkg::OPC_OP && if_instr[30]) begin
                        alu_op = rv_pkg::SUB;
                    end
                end
                3'b001: alu_op = rv_pkg::SLL;
                3'b010: alu_op = rv_pkg::SLT;
                3'b011: alu_op = rv_pkg::SLTU;
                3'b100: alu_op = rv_pkg::XOR;
                3'b101: alu_op = if_instr[30] ? rv_pkg::SRA : rv_pkg::SRL;
                3'b110: alu_op = rv_pkg::OR;
                default: alu_op = rv_pkg::AND;
            endcase
        end
    end

    always_comb begin
        case (id_opcode)
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_OPIMM,
            rv_pkg::OPC_OP,
            rv_pkg::OPC_LOAD,
            rv_pkg::OPC_JAL: wr_en = (rd != '0);
            default:         wr_en = 1'b0;
        endcase
    end

    always_comb begin
        op_a = pick(fwd_a, rf_data1);
        op_b = pick(fwd_b, rf_data2);
    end

    // ID/EX control, bubble on load-use or flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_opcode <= rv_pkg::OPC_OPIMM;
            ex_rd     <= '0;
            ex_alu_op <= rv_pkg::ADD;
            ex_wr_en  <= 1'b0;
        end else if (!interlock) begin
            if (stall || take_branch) begin
                ex_opcode <= rv_pkg::OPC_OPIMM;
                ex_rd     <= '0;
                ex_alu_op <= rv_pkg::ADD;
                ex_wr_en  <= 1'b0;
            end else begin
                ex_opcode <= id_opcode;
                ex_rd     <= rd;
                ex_alu_op <= alu_op;
                ex_wr_en  <= wr_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            ex_pc     <= if_pc;
            ex_a      <= op_a;
            ex_b      <= op_b;
            ex_imm    <= imm;
            ex_rs2    <= rs2_addr;
            ex_funct3 <= funct3;
        end
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  logic              wb_en,
    input  rv_pkg::reg_addr_t wb_addr,
    input  rv_pkg::word_t     wb_data,
    output rv_pkg::word_t     rf_data1,
    output rv_pkg::word_t     rf_data2
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_en && wb_addr == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_comb begin
        rf_data1 = read_port(rs1_addr);
        rf_data2 = read_port(rs2_addr);
    end

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::opcode_t   id_opcode,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::opcode_t   ex_opcode,
    input  logic              ex_wr_en,
    input  rv_pkg::reg_addr_t ex_rs2,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::opcode_t   mem_opcode,
    input  logic              mem_wr_en,
    input  logic              dmem_req,
    input  logic              imem_ack_n,
    input  logic              dmem_ack_n,
    output logic              stall,
    output logic              interlock,
    output rv_pkg::fwd_sel_e  fwd_a,
    output rv_pkg::fwd_sel_e  fwd_b,
    output logic              fwd_store
);

    logic id_reads_rs1;
    logic id_reads_rs2;
    logic ex_is_load;
    logic ex_fwd_ok;
    logic mem_result_ok;

    // EX result is the newer value, so it wins over MEM
    function automatic rv_pkg::fwd_sel_e select_src(input rv_pkg::reg_addr_t addr);
        if (ex_fwd_ok && ex_rd == addr) begin
            return rv_pkg::FWD_EX;
        end
        if (mem_wr_en && mem_rd == addr) begin
            return rv_pkg::FWD_MEM;
        end
        return rv_pkg::FWD_RF;
    endfunction

    assign id_reads_rs1 = id_opcode inside {rv_pkg::OPC_OPIMM, rv_pkg::OPC_OP, rv_pkg::OPC_LOAD,
                                            rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH};
    // Store data is picked up later in EX, so only OP and branches stall on rs2
    assign id_reads_rs2 = id_opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_BRANCH};

    assign ex_is_load = (ex_opcode == rv_pkg::OPC_LOAD);
    assign stall = ex_is_load && ex_wr_en &&
                   ((id_reads_rs1 && ex_rd == rs1_addr) || (id_reads_rs2 && ex_rd == rs2_addr));
    assign ex_fwd_ok = ex_wr_en && !ex_is_load;

    always_comb begin
        fwd_a = select_src(rs1_addr);
        fwd_b = select_src(rs2_addr);
    end

    assign mem_result_ok = mem_wr_en && (mem_opcode inside {rv_pkg::OPC_LUI, rv_pkg::OPC_OPIMM,
                                                            rv_pkg::OPC_OP, rv_pkg::OPC_LOAD});
    assign fwd_store = (ex_opcode == rv_pkg::OPC_STORE) && mem_result_ok && (mem_rd == ex_rs2);

    // Freeze the whole pipe while a memory is not ready
    assign interlock = imem_ack_n || (dmem_req && dmem_ack_n);

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              interlock,
    input  rv_pkg::word_t     ex_pc,
    input  rv_pkg::word_t     ex_a,
    input  rv_pkg::word_t     ex_b,
    input  rv_pkg::word_t     ex_imm,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::opcode_t   ex_opcode,
    input  rv_pkg::alu_op_e   ex_alu_op,
    input  logic [2:0]        ex_funct3,
    input  logic              ex_wr_en,
    input  logic              fwd_store,
    input  rv_pkg::word_t     mem_fwd_data,
    output rv_pkg::word_t     ex_result,
    output logic              take_branch,
    output rv_pkg::word_t     branch_target,
    output rv_pkg::word_t     mem_addr_res,
    output rv_pkg::word_t     mem_store_data,
    output rv_pkg::reg_addr_t mem_rd,
    output rv_pkg::opcode_t   mem_opcode,
    output logic              mem_wr_en
);

    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_out;
    rv_pkg::word_t store_data;
    logic          branch_cond;

    assign alu_b = (ex_opcode == rv_pkg::OPC_OP) ? ex_b : ex_imm;

    always_comb begin
        case (ex_alu_op)
            rv_pkg::SUB:    alu_out = ex_a - alu_b;
            rv_pkg::SLL:    alu_out = ex_a << alu_b[4:0];
            rv_pkg::SLT:    alu_out = {31'b0, $signed(ex_a) < $signed(alu_b)};
            rv_pkg::SLTU:   alu_out = {31'b0, ex_a < alu_b};
            rv_pkg::XOR:    alu_out = ex_a ^ alu_b;
            rv_pkg::SRL:    alu_out = ex_a >> alu_b[4:0];
            rv_pkg::SRA:    alu_out = $signed(ex_a) >>> alu_b[4:0];
            rv_pkg::OR:     alu_out = ex_a | alu_b;
            rv_pkg::AND:    alu_out = ex_a & alu_b;
            rv_pkg::PASS_B: alu_out = alu_b;
            default:        alu_out = ex_a + alu_b;
        endcase
    end

    // Link value for JAL
    assign ex_result = (ex_opcode == rv_pkg::OPC_JAL) ? ex_pc + 32'd4 : alu_out;

    // BEQ and BNE only, other branch types fall through
    always_comb begin
        case (ex_funct3)
            3'b000:  branch_cond = (ex_a == ex_b);
            3'b001:  branch_cond = (ex_a != ex_b);
            default: branch_cond = 1'b0;
        endcase
    end

    assign take_branch = (ex_opcode == rv_pkg::OPC_JAL) ||
                         (ex_opcode == rv_pkg::OPC_BRANCH && branch_cond);
    assign branch_target = ex_pc + ex_imm;

    assign store_data = fwd_store ? mem_fwd_data : ex_b;

    // EX/MEM register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rd     <= '0;
            mem_opcode <= rv_pkg::OPC_OPIMM;
            mem_wr_en  <= 1'b0;
        end else if (!interlock) begin
            mem_rd     <= ex_rd;
            mem_opcode <= ex_opcode;
            mem_wr_en  <= ex_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            mem_addr_res   <= ex_result;
            mem_store_data <= store_data;
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              interlock,
    input  rv_pkg::word_t     mem_addr_res,
    input  rv_pkg::word_t     mem_store_data,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::opcode_t   mem_opcode,
    input  logic              mem_wr_en,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::word_t     dmem_wdata,
    output logic              dmem_req,
    output logic              dmem_write,
    output rv_pkg::word_t     mem_fwd_data,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_addr,
    output rv_pkg::word_t     wb_data
);

    logic is_load;
    logic is_store;

    assign is_load  = (mem_opcode == rv_pkg::OPC_LOAD);
    assign is_store = (mem_opcode == rv_pkg::OPC_STORE);

    // Request stays up with stable address and data until acknowledged
    assign dmem_req   = is_load || is_store;
    assign dmem_write = is_store;
    assign dmem_addr  = mem_addr_res;
    assign dmem_wdata = mem_store_data;

    assign mem_fwd_data = is_load ? dmem_rdata : mem_addr_res;

    // MEM/WB register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en   <= 1'b0;
            wb_addr <= '0;
        end else if (!interlock) begin
            wb_en   <= mem_wr_en;
            wb_addr <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            wb_data <= mem_fwd_data;
        end
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          arst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    input  logic          imem_ack_n,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    input  rv_pkg::word_t dmem_rdata,
    output logic          dmem_req,
    output logic          dmem_write,
    input  logic          dmem_ack_n
);

    // Pipeline control
    logic stall;
    logic interlock;
    logic take_branch;
    logic fwd_store;
    rv_pkg::fwd_sel_e fwd_a;
    rv_pkg::fwd_sel_e fwd_b;

    // IF/ID and decode
    rv_pkg::word_t     if_pc;
    rv_pkg::word_t     if_instr;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::opcode_t   id_opcode;
    rv_pkg::word_t     rf_data1;
    rv_pkg::word_t     rf_data2;

    // ID/EX
    rv_pkg::word_t     ex_pc;
    rv_pkg::word_t     ex_a;
    rv_pkg::word_t     ex_b;
    rv_pkg::word_t     ex_imm;
    rv_pkg::reg_addr_t ex_rs2;
    rv_pkg::reg_addr_t ex_rd;
    rv_pkg::opcode_t   ex_opcode;
    rv_pkg::alu_op_e   ex_alu_op;
    logic [2:0]        ex_funct3;
    logic              ex_wr_en;
    rv_pkg::word_t     ex_result;
    rv_pkg::word_t     branch_target;

    // EX/MEM
    rv_pkg::word_t     mem_addr_res;
    rv_pkg::word_t     mem_store_data;
    rv_pkg::reg_addr_t mem_rd;
    rv_pkg::opcode_t   mem_opcode;
    logic              mem_wr_en;
    rv_pkg::word_t     mem_fwd_data;

    // MEM/WB
    logic              wb_en;
    rv_pkg::reg_addr_t wb_addr;
    rv_pkg::word_t     wb_data;

    fetch_stage fetch_stage_i (.*);

    decode_stage decode_stage_i (.*);

    regfile regfile_i (.*);

    hazard_unit hazard_unit_i (.*);

    execute_stage execute_stage_i (.*);

    mem_stage mem_stage_i (.*);

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic          clk,
    input  logic          arst_n,
    input  rv_pkg::word_t imem_addr,
    output rv_pkg::word_t imem_data,
    output logic          imem_ack_n,
    input  logic          dmem_req,
    input  logic          dmem_write,
    input  rv_pkg::word_t dmem_addr,
    input  rv_pkg::word_t dmem_wdata,
    output rv_pkg::word_t dmem_rdata,
    output logic          dmem_ack_n
);

    localparam int MEM_WORDS = 256;
    localparam int LOG_DEPTH = 64;

    rv_pkg::word_t imem [MEM_WORDS];
    rv_pkg::word_t dmem [MEM_WORDS];
    rv_pkg::word_t log_addr [LOG_DEPTH];
    rv_pkg::word_t log_data [LOG_DEPTH];
    int            log_count = 0;

    integer seed = 93040;
    int     imem_wait = 0;
    int     dmem_wait = 0;
    logic   advanced = 1'b0;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = '0;
        end
    end

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_req ? dmem[dmem_addr[9:2]] : '0;
    assign imem_ack_n = (imem_wait != 0);
    assign dmem_ack_n = (dmem_wait != 0);

    // The core only moves when neither memory holds it back
    always @(posedge clk) begin
        advanced <= 1'b0;
        if (arst_n && !imem_ack_n && !(dmem_req && dmem_ack_n)) begin
            advanced <= 1'b1;
            if (dmem_req && dmem_write) begin
                dmem[dmem_addr[9:2]] <= dmem_wdata;
                if (log_count < LOG_DEPTH) begin
                    log_addr[log_count] <= dmem_addr;
                    log_data[log_count] <= dmem_wdata;
                end
                log_count <= log_count + 1;
            end
        end
    end

    // New random wait of 0 to 2 cycles after each accepted access
    always @(negedge clk) begin
        if (!arst_n) begin
            imem_wait <= 0;
            dmem_wait <= 0;
        end else if (advanced) begin
            imem_wait <= $unsigned($random(seed)) % 3;
            dmem_wait <= $unsigned($random(seed)) % 3;
        end else begin
            if (imem_wait != 0) begin
                imem_wait <= imem_wait - 1;
            end
            if (dmem_wait != 0) begin
                dmem_wait <= dmem_wait - 1;
            end
        end
    end

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int            NUM_ROWS  = 10;
    localparam int            IMEM_SIZE = 256;
    localparam rv_pkg::word_t DONE_ADDR = 32'h0000_03fc;

    typedef struct packed {
        logic          alt;
        logic [2:0]    funct3;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t result;
    } alu_row_t;

    // funct7 bit 5, funct3, rs1 value, rs2 value, expected rd
    alu_row_t alu_rows [NUM_ROWS] = '{
        '{1'b0, 3'b000, 32'h1234_5678, 32'h0fed_cba9, 32'h2222_2221},
        '{1'b1, 3'b000, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe},
        '{1'b0, 3'b001, 32'h8000_0001, 32'h0000_0024, 32'h0000_0010},
        '{1'b0, 3'b010, 32'hffff_fff0, 32'h0000_0003, 32'h0000_0001},
        '{1'b0, 3'b011, 32'hffff_fff0, 32'h0000_0003, 32'h0000_0000},
        '{1'b0, 3'b100, 32'ha5a5_f00f, 32'h5a5a_0ff0, 32'hffff_ffff},
        '{1'b0, 3'b101, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001},
        '{1'b1, 3'b101, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000},
        '{1'b0, 3'b110, 32'h00f0_0f00, 32'h0f00_00f0, 32'h0ff0_0ff0},
        '{1'b0, 3'b111, 32'hdead_beef, 32'h0f0f_0f0f, 32'h0e0d_0e0f}
    };

    logic          clk = 1'b0;
    logic          arst_n = 1'b0;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_data;
    logic          imem_ack_n;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    rv_pkg::word_t dmem_rdata;
    logic          dmem_req;
    logic          dmem_write;
    logic          dmem_ack_n;

    rv_pkg::word_t prog [$];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    int            cycle_count = 0;
    int            timeout_cycles = 1000;

    rv_core rv_core_i (.*);

    tb_mem_model mem_model_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > timeout_cycles) begin
                $display("Timeout: final store not seen after %0d cycles", cycle_count);
                $display("STATUS: FAIL");
                $fatal(1);
            end
        end
    end

    task automatic check_value(input string name, input rv_pkg::word_t actual,
                               input rv_pkg::word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    function automatic rv_pkg::word_t enc_u(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t v);
        rv_pkg::word_t hi;
        // Round up so that the sign-extended ADDI part lands on v
        hi = v + 32'h800;
        return {hi[31:12], rd, rv_pkg::OPC_LUI};
    endfunction

    function automatic rv_pkg::word_t enc_i(input rv_pkg::opcode_t opc,
                                            input rv_pkg::reg_addr_t rd, input logic [2:0] f3,
                                            input rv_pkg::reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::word_t enc_r(input logic alt, input logic [2:0] f3,
                                            input rv_pkg::reg_addr_t rd,
                                            input rv_pkg::reg_addr_t rs1,
                                            input rv_pkg::reg_addr_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::word_t enc_s(input rv_pkg::reg_addr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input rv_pkg::reg_addr_t rs1,
                                            input rv_pkg::reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_j(input rv_pkg::reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    task automatic expect_store(input rv_pkg::word_t addr, input rv_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_program();
        rv_pkg::word_t addr;
        rv_pkg::word_t branch_pc;
        for (int r = 0; r < NUM_ROWS; r++) begin
            addr = 4 * r;
            // Interleaved so that the ADDIs pick up the LUIs from MEM
            prog.push_back(enc_u(5'd1, alu_rows[r].a));
            prog.push_back(enc_u(5'd2, alu_rows[r].b));
            prog.push_back(enc_i(rv_pkg::OPC_OPIMM, 5'd1, 3'b000, 5'd1, alu_rows[r].a[11:0]));
            prog.push_back(enc_i(rv_pkg::OPC_OPIMM, 5'd2, 3'b000, 5'd2, alu_rows[r].b[11:0]));
            prog.push_back(enc_r(alu_rows[r].alt, alu_rows[r].funct3, 5'd3, 5'd1, 5'd2));
            prog.push_back(enc_s(5'd3, addr[11:0]));
            expect_store(addr, alu_rows[r].result);
        end
        // Load-use, then a store fed straight from a load
        prog.push_back(enc_i(rv_pkg::OPC_LOAD, 5'd4, 3'b010, 5'd0, 12'h000));
        prog.push_back(enc_i(rv_pkg::OPC_OPIMM, 5'd5, 3'b000, 5'd4, 12'h123));
        prog.push_back(enc_s(5'd5, 12'h100));
        expect_store(32'h100, alu_rows[0].result + 32'h123);
        prog.push_back(enc_i(rv_pkg::OPC_LOAD, 5'd6, 3'b010, 5'd0, 12'h100));
        prog.push_back(enc_s(5'd6, 12'h104));
        expect_store(32'h104, alu_rows[0].result + 32'h123);
        branch_pc = 4 * prog.size();
        prog.push_back(enc_b(3'b000, 5'd3, 5'd3, 13'd12));
        prog.push_back(enc_s(5'd3, 12'h200));
        prog.push_back(enc_s(5'd3, 12'h204));
        prog.push_back(enc_j(5'd7, 21'd12));
        prog.push_back(enc_s(5'd3, 12'h208));
        prog.push_back(enc_s(5'd3, 12'h20c));
        prog.push_back(enc_s(5'd7, 12'h110));
        expect_store(32'h110, branch_pc + 32'd16);
        prog.push_back(enc_b(3'b001, 5'd3, 5'd3, 13'd8));
        prog.push_back(enc_s(5'd3, 12'h114));
        expect_store(32'h114, alu_rows[NUM_ROWS - 1].result);
        prog.push_back(enc_i(rv_pkg::OPC_OPIMM, 5'd8, 3'b000, 5'd0, 12'h07d));
        prog.push_back(enc_s(5'd8, DONE_ADDR[11:0]));
        expect_store(DONE_ADDR, 32'h0000_007d);
        // Park on a jump to itself
        prog.push_back(enc_j(5'd0, 21'd0));
    endtask

    function automatic bit final_store_seen();
        int n;
        n = mem_model_i.log_count;
        return n > 0 && n <= 64 && mem_model_i.log_addr[n - 1] == DONE_ADDR;
    endfunction

    initial begin
        build_program();
        timeout_cycles = prog.size() * 8 + 200;
        for (int k = 0; k < IMEM_SIZE; k++) begin
            mem_model_i.imem[k] = (k < prog.size()) ? prog[k] : rv_pkg::NOP_INSTR;
        end
        repeat (10) @(negedge clk);
        check_value("imem_addr", imem_addr, 32'h0000_0000);
        check_value("dmem_req", dmem_req, 0);
        check_value("dmem_write", dmem_write, 0);
        arst_n = 1'b1;
        while (!final_store_seen()) begin
            @(negedge clk);
        end
        check_value("store count", mem_model_i.log_count, exp_addr.size());
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_value($sformatf("dmem_addr of store %0d", i), mem_model_i.log_addr[i],
                        exp_addr[i]);
            check_value($sformatf("dmem_wdata of store %0d", i), mem_model_i.log_data[i],
                        exp_data[i]);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- rv_core.f
rv_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
hazard_unit.sv
execute_stage.sv
mem_stage.sv
rv_core.sv
tb_mem_model.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - regfile.sv
  - hazard_unit.sv
  - execute_stage.sv
  - mem_stage.sv
  - rv_core.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_rv_core.sv
